/* rtl/i2s_loop_pkg.sv */
package i2s_loop_pkg;

	////////////////////////////////////////////////////////////
	// sample format and pattern
	////////////////////////////////////////////////////////////

	// bits per audio word
	localparam int sample_width = 24;

	// bit clocks in one channel slot
	localparam int slot_bits = 32;

	// entries in the test pattern
	localparam int pattern_depth = 5;

	// fixed loopback pattern, stepped through cyclically
	localparam logic [sample_width-1:0] test_pattern [pattern_depth] = '{
		24'h123456,
		24'h345678,
		24'h567890,
		24'h789012,
		24'h901234
	};

	////////////////////////////////////////////////////////////
	// enums
	////////////////////////////////////////////////////////////

	// channel tag, follows lrclk level
	typedef enum logic {
		ch_left  = 1'b0,
		ch_right = 1'b1
	} channel_e;

	// transmitter slot state
	typedef enum logic [1:0] {
		tx_idle  = 2'd0,
		tx_left  = 2'd1,
		tx_right = 2'd2
	} tx_state_e;

	////////////////////////////////////////////////////////////
	// bundles
	////////////////////////////////////////////////////////////

	// tagged word, channel flag on top
	typedef struct packed {
		channel_e                channel;
		logic [sample_width-1:0] data;
	} audio_sample_t;

	// serial lines between tx and rx
	typedef struct packed {
		logic bclk;
		logic lrclk;
		logic sd;
	} i2s_lines_t;

endpackage

/* rtl/test_pattern_source.sv */
module test_pattern_source import i2s_loop_pkg::*; (
	input  logic                    read_testdata_en,
	input  logic                    rst,
	input  logic                    next_sample,
	output logic [sample_width-1:0] pattern_sample
);

	// index into the pattern table
	localparam int idx_w = (pattern_depth > 1) ? $clog2(pattern_depth) : 1;

	// last valid entry, wrap point
	localparam logic [idx_w-1:0] idx_last = idx_w'(pattern_depth - 1);

	logic [idx_w-1:0] index;

	////////////////////////////////////////////////////////////
	// index register
	////////////////////////////////////////////////////////////

	// steps once per transmitter request
	always_ff @(posedge read_testdata_en) begin
		if (!rst) begin
			index <= '0;
		end else if (next_sample) begin
			// wrap after the last entry
			if (index == idx_last) begin
				index <= '0;
			end else begin
				index <= index + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// table read
	////////////////////////////////////////////////////////////

	// current entry, taken by tx in the request cycle
	assign pattern_sample = test_pattern[index];

endmodule

/* rtl/i2s_transmitter.sv */
module i2s_transmitter import i2s_loop_pkg::*; #(
	parameter int bclk_div = 2
) (
	input  logic                    read_testdata_en,
	input  logic                    rst,
	input  logic                    run,
	input  logic [sample_width-1:0] pattern_sample,
	output logic                    next_sample,
	output i2s_lines_t              lines
);

	// divider and bit counter sizes
	localparam int div_w = $clog2(bclk_div + 1);
	localparam int bit_w = $clog2(slot_bits);

	localparam logic [div_w-1:0] div_last = div_w'(bclk_div - 1);
	localparam logic [bit_w-1:0] bit_last = bit_w'(slot_bits - 1);

	tx_state_e               state;
	logic [div_w-1:0]        div_cnt;
	logic [bit_w-1:0]        bit_cnt;
	logic [sample_width-1:0] shreg;

	logic half_tick;
	logic fall_tick;
	logic slot_end;
	logic start_run;

	////////////////////////////////////////////////////////////
	// bit clock timing
	////////////////////////////////////////////////////////////

	// bclk flips at the end of each half period
	assign half_tick = (state != tx_idle) && (div_cnt == div_last);
	// high to low transition, data and ws change here
	assign fall_tick = half_tick && lines.bclk;
	// last bit period of the slot done
	assign slot_end  = fall_tick && (bit_cnt == bit_last);
	// leaving idle, always into a left slot
	assign start_run = (state == tx_idle) && run;

	// request a word at every slot start, none when stopping
	assign next_sample = start_run || (slot_end && ((state == tx_left) || run));

	////////////////////////////////////////////////////////////
	// framing FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge read_testdata_en) begin
		if (!rst) begin
			state   <= tx_idle;
			div_cnt <= '0;
			bit_cnt <= '0;
			lines   <= '0;
		end else begin
			// divider idles at zero, bclk stays low
			if ((state == tx_idle) || half_tick) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			if (half_tick) begin
				lines.bclk <= ~lines.bclk;
			end

			if (start_run) begin
				state       <= tx_left;
				bit_cnt     <= '0;
				lines.lrclk <= 1'b0;
				lines.sd    <= 1'b0;
			end else if (slot_end) begin
				// delay bit of the new slot is a zero
				bit_cnt  <= '0;
				lines.sd <= 1'b0;
				case (state)
					tx_left: begin
						state       <= tx_right;
						lines.lrclk <= 1'b1;
					end
					tx_right: begin
						// stop only after a full stereo frame
						state       <= run ? tx_left : tx_idle;
						lines.lrclk <= 1'b0;
					end
					default: state <= tx_idle;
				endcase
			end else if (fall_tick) begin
				// msb first, zeros once the word is out
				bit_cnt  <= bit_cnt + 1'b1;
				lines.sd <= shreg[sample_width-1];
			end
		end
	end

	// serializer, loaded at slot start
	always_ff @(posedge read_testdata_en) begin
		if (next_sample) begin
			shreg <= pattern_sample;
		end else if (fall_tick) begin
			shreg <= {shreg[sample_width-2:0], 1'b0};
		end
	end

endmodule

/* rtl/i2s_receiver.sv */
module i2s_receiver import i2s_loop_pkg::*; (
	input  logic          read_testdata_en,
	input  logic          rst,
	input  i2s_lines_t    lines,
	output audio_sample_t rx_sample,
	output logic          rx_valid
);

	// counts delay bit plus data bits, then holds
	localparam int cnt_w = $clog2(sample_width + 2);

	// index of the last data bit
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(sample_width);
	// word complete, padding ignored from here
	localparam logic [cnt_w-1:0] cnt_done = cnt_w'(sample_width + 1);

	logic                    bclk_q;
	logic                    lrclk_q;
	logic                    bclk_rise;
	logic                    ws_change;
	logic [cnt_w-1:0]        rx_cnt;
	logic [sample_width-1:0] shreg;
	channel_e                channel;

	////////////////////////////////////////////////////////////
	// line edge detection
	////////////////////////////////////////////////////////////

	// sd is stable around the rising edge
	assign bclk_rise = lines.bclk && !bclk_q;
	// new slot on any ws level change
	assign ws_change = lines.lrclk != lrclk_q;

	// tagged word straight from the shifter
	assign rx_sample.channel = channel;
	assign rx_sample.data    = shreg;

	////////////////////////////////////////////////////////////
	// slot tracking
	////////////////////////////////////////////////////////////

	// reset arms for a left slot, tx starts there
	always_ff @(posedge read_testdata_en) begin
		if (!rst) begin
			bclk_q   <= 1'b0;
			lrclk_q  <= 1'b0;
			rx_cnt   <= '0;
			channel  <= ch_left;
			rx_valid <= 1'b0;
		end else begin
			bclk_q   <= lines.bclk;
			lrclk_q  <= lines.lrclk;
			// strobe once the last data bit is in
			rx_valid <= bclk_rise && (rx_cnt == cnt_last);
			if (ws_change) begin
				rx_cnt  <= '0;
				channel <= channel_e'(lines.lrclk);
			end else if (bclk_rise && (rx_cnt != cnt_done)) begin
				rx_cnt <= rx_cnt + 1'b1;
			end
		end
	end

	// deserializer, skips count 0 which is the delay bit
	always_ff @(posedge read_testdata_en) begin
		if (bclk_rise && (rx_cnt != '0) && (rx_cnt <= cnt_last)) begin
			shreg <= {shreg[sample_width-2:0], lines.sd};
		end
	end

endmodule

/* rtl/sample_fifo.sv */
module sample_fifo import i2s_loop_pkg::*; #(
	parameter int fifo_depth   = 8,
	parameter int credit_width = 4
) (
	input  logic          read_testdata_en,
	input  logic          rst,
	input  audio_sample_t rx_sample,
	input  logic          rx_valid,
	input  logic          credit_return,
	output audio_sample_t out_word,
	output logic          out_valid,
	output logic          overflow
);

	// pointer and occupancy sizes
	localparam int ptr_w   = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int count_w = $clog2(fifo_depth + 1);

	localparam logic [ptr_w-1:0]        ptr_last   = ptr_w'(fifo_depth - 1);
	localparam logic [count_w-1:0]      count_full = count_w'(fifo_depth);
	localparam logic [credit_width-1:0] credit_max = '1;

	audio_sample_t           mem [fifo_depth];
	logic [ptr_w-1:0]        wr_ptr;
	logic [ptr_w-1:0]        rd_ptr;
	logic [count_w-1:0]      count;
	logic [credit_width-1:0] credits;

	logic full;
	logic wr_en;
	logic send;

	// drop when full, send on data plus credit
	assign full  = count == count_full;
	assign wr_en = rx_valid && !full;
	assign send  = (count != '0) && (credits != '0);

	////////////////////////////////////////////////////////////
	// pointers, occupancy, overflow
	////////////////////////////////////////////////////////////

	always_ff @(posedge read_testdata_en) begin
		if (!rst) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			overflow  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= send;
			// circular wrap for any depth
			if (wr_en) begin
				wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
			end
			if (send) begin
				rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
			end
			if (wr_en && !send) begin
				count <= count + 1'b1;
			end else if (send && !wr_en) begin
				count <= count - 1'b1;
			end
			// sticky until reset
			if (rx_valid && full) begin
				overflow <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// credit counter
	////////////////////////////////////////////////////////////

	// return and send together cancel out
	always_ff @(posedge read_testdata_en) begin
		if (!rst) begin
			credits <= '0;
		end else if (credit_return && !send && (credits != credit_max)) begin
			credits <= credits + 1'b1;
		end else if (send && !credit_return) begin
			credits <= credits - 1'b1;
		end
	end

	// storage and output word
	always_ff @(posedge read_testdata_en) begin
		if (wr_en) begin
			mem[wr_ptr] <= rx_sample;
		end
		if (send) begin
			out_word <= mem[rd_ptr];
		end
	end

endmodule

/* rtl/i2s_loopback_top.sv */
module i2s_loopback_top import i2s_loop_pkg::*; #(
	parameter int bclk_div     = 2,
	parameter int fifo_depth   = 8,
	parameter int credit_width = 4
) (
	input  logic          read_testdata_en,
	input  logic          rst,
	input  logic          run,
	input  logic          credit_return,
	output audio_sample_t out_word,
	output logic          out_valid,
	output logic          overflow
);

	// source handshake
	logic                    next_sample;
	logic [sample_width-1:0] pattern_sample;

	// serial lines, internal only
	i2s_lines_t lines;

	// recovered words into the buffer
	audio_sample_t rx_sample;
	logic          rx_valid;

	////////////////////////////////////////////////////////////
	// transmit side
	////////////////////////////////////////////////////////////

	test_pattern_source source_i (
		.read_testdata_en (read_testdata_en),
		.rst              (rst),
		.next_sample      (next_sample),
		.pattern_sample   (pattern_sample)
	);

	i2s_transmitter #(
		.bclk_div (bclk_div)
	) tx_i (
		.read_testdata_en (read_testdata_en),
		.rst              (rst),
		.run              (run),
		.pattern_sample   (pattern_sample),
		.next_sample      (next_sample),
		.lines            (lines)
	);

	////////////////////////////////////////////////////////////
	// receive side
	////////////////////////////////////////////////////////////

	i2s_receiver rx_i (
		.read_testdata_en (read_testdata_en),
		.rst              (rst),
		.lines            (lines),
		.rx_sample        (rx_sample),
		.rx_valid         (rx_valid)
	);

	// credit gated output buffer
	sample_fifo #(
		.fifo_depth   (fifo_depth),
		.credit_width (credit_width)
	) fifo_i (
		.read_testdata_en (read_testdata_en),
		.rst              (rst),
		.rx_sample        (rx_sample),
		.rx_valid         (rx_valid),
		.credit_return    (credit_return),
		.out_word         (out_word),
		.out_valid        (out_valid),
		.overflow         (overflow)
	);

endmodule

/* verification/i2s_loopback_properties.sv */
module i2s_loopback_properties #(
	parameter int fifo_depth = 8
) (
	input logic                              read_testdata_en,
	input logic                              rst,
	input logic                              rx_valid,
	input logic                              credit_return,
	input logic                              out_valid,
	input logic                              overflow,
	input logic [$clog2(fifo_depth + 1)-1:0] count
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int count_w = $clog2(fifo_depth + 1);
	localparam logic [count_w-1:0] count_full = count_w'(fifo_depth);

	// number of failed assertions so far
	int assert_failures = 0;

	// words accepted, credits returned, words sent since reset
	int written;
	int returned;
	int sent;

	////////////////////////////////////////////////////////////
	// consumer side bookkeeping
	////////////////////////////////////////////////////////////

	// full buffer drops the incoming word
	always_ff @(posedge read_testdata_en) begin
		if (!rst) begin
			written  <= 0;
			returned <= 0;
			sent     <= 0;
		end else begin
			if (rx_valid && (count != count_full)) begin
				written <= written + 1;
			end
			if (credit_return) begin
				returned <= returned + 1;
			end
			if (out_valid) begin
				sent <= sent + 1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// fifo rules
	////////////////////////////////////////////////////////////

	// each word leaves against an earlier credit and an earlier write
	send_needs_data_and_credit: assert property (
		@(posedge read_testdata_en) disable iff (!rst)
		out_valid |-> ((sent < returned) && (sent < written))
	) else begin
		$error("fifo sent a word without a credit or without data");
		assert_failures++;
	end

	occupancy_in_range: assert property (
		@(posedge read_testdata_en) disable iff (!rst)
		count <= count_full
	) else begin
		$error("fifo occupancy above its depth");
		assert_failures++;
	end

	// sticky until the next reset
	overflow_sticky: assert property (
		@(posedge read_testdata_en) disable iff (!rst)
		$past(overflow) |-> overflow
	) else begin
		$error("overflow flag dropped without a reset");
		assert_failures++;
	end

endmodule

// attached to every fifo instance
bind sample_fifo i2s_loopback_properties #(
	.fifo_depth (fifo_depth)
) props_i (
	.read_testdata_en (read_testdata_en),
	.rst              (rst),
	.rx_valid         (rx_valid),
	.credit_return    (credit_return),
	.out_valid        (out_valid),
	.overflow         (overflow),
	.count            (count)
);

/* verification/i2s_loopback_tb.sv */
module i2s_loopback_tb import i2s_loop_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// cycles per channel slot with the default divider
	localparam int bclk_div    = 2;
	localparam int slot_cycles = slot_bits * 2 * bclk_div;
	localparam int num_tests   = 5;
	localparam int margin      = 2000;

	// one table row, gap and spacing counted in slots
	typedef struct {
		string name;
		bit    do_reset;
		int    credits;
		int    gap_slots;
		int    spacing;
		bit    expect_overflow;
	} test_row_t;

	logic          read_testdata_en;
	logic          rst;
	logic          run;
	logic          credit_return;
	audio_sample_t out_word;
	logic          out_valid;
	logic          overflow;

	test_row_t tests [num_tests];

	int errors            = 0;
	int words_received    = 0;
	int credits_returned  = 0;
	int expected_index    = 0;
	int cycle_limit       = 0;
	int cycle_count       = 0;
	bit overflow_expected = 1'b0;

	i2s_loopback_top dut_i (
		.read_testdata_en (read_testdata_en),
		.rst              (rst),
		.run              (run),
		.credit_return    (credit_return),
		.out_word         (out_word),
		.out_valid        (out_valid),
		.overflow         (overflow)
	);

	// 20 ns period
	always #10 read_testdata_en = ~read_testdata_en;

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected) begin
			$display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
			errors++;
		end
	endtask

	// word k carries entry k mod depth
	function automatic logic [sample_width-1:0] expected_data(input int k);
		return test_pattern[k % pattern_depth];
	endfunction

	// slots alternate, left first
	function automatic channel_e expected_channel(input int k);
		return (k % 2 == 0) ? ch_left : ch_right;
	endfunction

	task automatic fill_table();
		tests[0] = '{"reset_state", 1'b1, 0, 3, 0, 1'b0};
		tests[1] = '{"content_order", 1'b0, 12, 0, 0, 1'b0};
		tests[2] = '{"credit_accounting", 1'b0, 3, 0, 3, 1'b0};
		// more than fifo_depth + 2 slots without credits
		tests[3] = '{"backpressure_overflow", 1'b0, 8, 12, 0, 1'b1};
		tests[4] = '{"reset_recovery", 1'b1, 4, 0, 0, 1'b0};
	endtask

	// one slot per credit, plus every withheld slot
	function automatic int limit_from_table();
		int total_credits;
		int held_slots;
		total_credits = 0;
		held_slots    = 0;
		foreach (tests[i]) begin
			total_credits += tests[i].credits;
			held_slots    += tests[i].gap_slots;
			if (tests[i].credits > 1) begin
				held_slots += tests[i].spacing * (tests[i].credits - 1);
			end
		end
		return (total_credits + held_slots) * slot_cycles + margin;
	endfunction

	task automatic apply_reset();
		@(negedge read_testdata_en);
		rst = 1'b0;
		repeat (16) begin
			@(negedge read_testdata_en);
			check_value(32'(out_valid), 32'd0, "out_valid during reset");
			check_value(32'(overflow), 32'd0, "overflow during reset");
		end
		// reference restarts at entry 0
		words_received   = 0;
		credits_returned = 0;
		expected_index   = 0;
		rst              = 1'b1;
	endtask

	// single-cycle pulse, low cycle after it
	task automatic return_credit();
		@(negedge read_testdata_en);
		credit_return = 1'b1;
		credits_returned++;
		@(negedge read_testdata_en);
		credit_return = 1'b0;
	endtask

	task automatic wait_slots(input int n);
		repeat (n * slot_cycles) @(negedge read_testdata_en);
	endtask

	////////////////////////////////////////////////////////////
	// output monitor and reference model
	////////////////////////////////////////////////////////////

	// registered outputs, old values seen at the edge
	always @(posedge read_testdata_en) begin
		if (rst && out_valid) begin
			check_value(32'(words_received < credits_returned), 32'd1,
				"word sent without a held credit");
			check_value(32'(out_word.data), 32'(expected_data(expected_index)), "sample data");
			check_value(32'(out_word.channel), 32'(expected_channel(expected_index)),
				"channel tag");
			if (overflow_expected) begin
				check_value(32'(overflow), 32'd1, "overflow while draining");
			end
			expected_index++;
			words_received++;
		end
	end

	////////////////////////////////////////////////////////////
	// watchdog
	////////////////////////////////////////////////////////////

	initial begin : watchdog
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge read_testdata_en);
			cycle_count++;
		end
		$display("timeout: tests still running after %0d clock cycles", cycle_limit);
		$display("Verification failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// table-driven stimulus
	////////////////////////////////////////////////////////////

	initial begin : main
		int words_at_start;
		int errors_at_start;
		int tests_passed;
		int tests_failed;
		int props_failed;
		read_testdata_en = 1'b0;
		rst              = 1'b0;
		run              = 1'b0;
		credit_return    = 1'b0;
		tests_passed     = 0;
		tests_failed     = 0;
		fill_table();
		cycle_limit = limit_from_table();
		// transmitter free runs, never stalled
		run = 1'b1;
		for (int i = 0; i < num_tests; i++) begin
			errors_at_start = errors;
			if (tests[i].do_reset) begin
				apply_reset();
			end
			words_at_start = words_received;
			wait_slots(tests[i].gap_slots);
			if (tests[i].expect_overflow) begin
				check_value(32'(overflow), 32'd1, "overflow after withheld credits");
			end
			overflow_expected = tests[i].expect_overflow;
			for (int c = 0; c < tests[i].credits; c++) begin
				if (c > 0) begin
					wait_slots(tests[i].spacing);
				end
				return_credit();
			end
			// out_valid marks arrival, then a quiet slot
			while (words_received < credits_returned) begin
				@(negedge read_testdata_en);
			end
			wait_slots(1);
			overflow_expected = 1'b0;
			check_value(32'(words_received - words_at_start), 32'(tests[i].credits), "word count");
			check_value(32'(overflow), 32'(tests[i].expect_overflow), "overflow flag");
			if (errors == errors_at_start) begin
				tests_passed++;
			end else begin
				tests_failed++;
			end
			$display("test %0d %s: %0d words, %0d errors, %s", i, tests[i].name,
				words_received - words_at_start, errors - errors_at_start,
				(errors == errors_at_start) ? "ok" : "not ok");
		end
		props_failed = dut_i.fifo_i.props_i.assert_failures;
		$display("summary: %0d tests ok, %0d tests not ok, %0d assertion failures",
			tests_passed, tests_failed, props_failed);
		if ((tests_failed == 0) && (errors == 0) && (props_failed == 0)) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* sources.f */
rtl/i2s_loop_pkg.sv
rtl/test_pattern_source.sv
rtl/i2s_transmitter.sv
rtl/i2s_receiver.sv
rtl/sample_fifo.sv
rtl/i2s_loopback_top.sv
verification/i2s_loopback_properties.sv
verification/i2s_loopback_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the I2S loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module i2s_loopback_tb \
	-f sources.f -o sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim +verilator+error+limit+100 > sim.log 2>&1

grep -q "^Verification passed$" sim.log \
	&& { echo "simulation ok"; exit 0; } \
	|| { echo "simulation reported errors, see sim.log"; exit 1; }
